//--- afifo_cfg.svh
`ifndef AFIFO_CFG_SVH
`define AFIFO_CFG_SVH

`default_nettype none

// ####################################################################
// fifo geometry
// ####################################################################

`define AFIFO_DATA_WIDTH 8
`define AFIFO_DEPTH      16
`define AFIFO_ADDR_WIDTH 4   // log2 of depth

// flag thresholds, in words held
`define AFIFO_AFULL      12  // afull at or above this fill
`define AFIFO_AEMPTY     2   // aempty at or below this fill

`default_nettype wire

`endif

//--- afifo_pkg.sv
`include "afifo_cfg.svh"

`default_nettype none

package afifo_pkg;

  // address bits plus one wrap bit, same type for binary and gray
  typedef logic [`AFIFO_ADDR_WIDTH:0] ptr_t;

  typedef logic [`AFIFO_DATA_WIDTH-1:0] data_t;

  typedef struct packed {
    logic  en;
    data_t data;
  } wr_req_t;

  typedef struct packed {
    logic  valid;  // one rd_clk cycle after an accepted read
    data_t data;
  } rd_resp_t;

  typedef struct packed {
    logic full;
    logic afull;
  } wr_status_t;

  typedef struct packed {
    logic empty;
    logic aempty;
  } rd_status_t;

  function automatic ptr_t bin2gray(ptr_t b);
    return b ^ (b >> 1);
  endfunction

  function automatic ptr_t gray2bin(ptr_t g);
    ptr_t b;
    b[$bits(ptr_t)-1] = g[$bits(ptr_t)-1];
    for (int i = $bits(ptr_t) - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

endpackage

`default_nettype wire

//--- afifo_ram.sv
`timescale 1ns/10ps

`include "afifo_cfg.svh"

`default_nettype none

module afifo_ram (
  input  wire                         wr_clk,
  input  wire                         we,
  input  wire [`AFIFO_ADDR_WIDTH-1:0] waddr,
  input  wire afifo_pkg::data_t       wdata,
  input  wire                         rd_clk,
  input  wire                         re,
  input  wire [`AFIFO_ADDR_WIDTH-1:0] raddr,
  output afifo_pkg::data_t            rdata
);

  import afifo_pkg::*;

  // ####################################################################
  // storage array
  // ####################################################################

  data_t mem [`AFIFO_DEPTH];

  // write port, wr_clk domain
  always_ff @(posedge wr_clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // ####################################################################
  // read port
  // ####################################################################

  // registered read, the word shows up one rd_clk after re
  // the entry at raddr was written at least two rd_clk edges earlier,
  // since the write pointer only reaches this domain through the sync
  always_ff @(posedge rd_clk) begin
    if (re) begin
      rdata <= mem[raddr];
    end
  end

endmodule

`default_nettype wire

//--- afifo_ptr_sync.sv
`timescale 1ns/10ps

`default_nettype none

module afifo_ptr_sync (
  input  wire                   clk,    // destination domain clock
  input  wire                   rst_n,
  input  wire afifo_pkg::ptr_t  ptr_gray,
  output afifo_pkg::ptr_t       ptr_bin
);

  import afifo_pkg::*;

  // ####################################################################
  // two-flop synchronizer
  // ####################################################################

  ptr_t sync_q1;  // may go metastable
  ptr_t sync_q2;

  // only one bit of ptr_gray changes per source edge, so a late
  // capture lands on either the old or the new pointer value
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= ptr_gray;
      sync_q2 <= sync_q1;
    end
  end

  // ####################################################################
  // back to binary for the fill arithmetic
  // ####################################################################

  always_comb begin
    ptr_bin = gray2bin(sync_q2);
  end

endmodule

`default_nettype wire

//--- afifo_wr_ctrl.sv
`timescale 1ns/10ps

`include "afifo_cfg.svh"

`default_nettype none

module afifo_wr_ctrl (
  input  wire                          wr_clk,
  input  wire                          wr_rst_n,
  input  wire afifo_pkg::wr_req_t      wr_req,
  input  wire afifo_pkg::ptr_t         rd_ptr_sync,  // binary, already in wr_clk
  output afifo_pkg::wr_status_t        wr_status,
  output logic                         ram_we,
  output logic [`AFIFO_ADDR_WIDTH-1:0] ram_waddr,
  output afifo_pkg::ptr_t              wr_ptr_gray
);

  import afifo_pkg::*;

  logic wr_accept;
  ptr_t wr_ptr;
  ptr_t wr_ptr_nxt;
  ptr_t wr_fill_nxt;

  // ####################################################################
  // write acceptance and pointer
  // ####################################################################

  // back-pressure, a write while full is simply dropped
  assign wr_accept = wr_req.en & ~wr_status.full;

  assign wr_ptr_nxt = wr_ptr + ptr_t'(wr_accept);

  // words held after this edge, as seen from the write side
  // the read pointer copy is stale, so this can only overestimate
  assign wr_fill_nxt = wr_ptr_nxt - rd_ptr_sync;

  assign ram_we    = wr_accept;
  assign ram_waddr = wr_ptr[`AFIFO_ADDR_WIDTH-1:0];  // wrap bit dropped

  always_ff @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      wr_ptr      <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_ptr      <= wr_ptr_nxt;
      wr_ptr_gray <= bin2gray(wr_ptr_nxt);  // registered, no glitch on the crossing
    end
  end

  // ####################################################################
  // registered flags
  // ####################################################################

  // both flags come from the next pointer so they move on the same
  // edge that takes the write
  always_ff @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      wr_status.full  <= 1'b0;
      wr_status.afull <= 1'b0;
    end else begin
      wr_status.full  <= (wr_fill_nxt == ptr_t'(`AFIFO_DEPTH));
      wr_status.afull <= (wr_fill_nxt >= ptr_t'(`AFIFO_AFULL));
    end
  end

endmodule

`default_nettype wire

//--- afifo_rd_ctrl.sv
`timescale 1ns/10ps

`include "afifo_cfg.svh"

`default_nettype none

module afifo_rd_ctrl (
  input  wire                          rd_clk,
  input  wire                          rd_rst_n,
  input  wire                          rd_en,
  input  wire afifo_pkg::ptr_t         wr_ptr_sync,  // binary, already in rd_clk
  output afifo_pkg::rd_status_t        rd_status,
  output logic                         ram_re,
  output logic [`AFIFO_ADDR_WIDTH-1:0] ram_raddr,
  output afifo_pkg::ptr_t              rd_ptr_gray,
  output logic                         rd_valid
);

  import afifo_pkg::*;

  logic rd_accept;
  ptr_t rd_ptr;
  ptr_t rd_ptr_nxt;
  ptr_t rd_level_nxt;

  // ####################################################################
  // read acceptance and pointer
  // ####################################################################

  assign rd_accept = rd_en & ~rd_status.empty;  // reads on empty are ignored

  assign rd_ptr_nxt = rd_ptr + ptr_t'(rd_accept);

  // words left after this edge, the write pointer copy lags so this
  // never shows more than is really there
  assign rd_level_nxt = wr_ptr_sync - rd_ptr_nxt;

  assign ram_re    = rd_accept;
  assign ram_raddr = rd_ptr[`AFIFO_ADDR_WIDTH-1:0];

  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      rd_ptr      <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_ptr      <= rd_ptr_nxt;
      rd_ptr_gray <= bin2gray(rd_ptr_nxt);
    end
  end

  // ####################################################################
  // registered flags and data valid
  // ####################################################################

  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      rd_status.empty  <= 1'b1;
      rd_status.aempty <= 1'b1;
    end else begin
      rd_status.empty  <= (rd_level_nxt == '0);
      rd_status.aempty <= (rd_level_nxt <= ptr_t'(`AFIFO_AEMPTY));
    end
  end

  // lines up with the ram read register
  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_accept;
    end
  end

endmodule

`default_nettype wire

//--- async_fifo.sv
`timescale 1ns/10ps

`include "afifo_cfg.svh"

`default_nettype none

module async_fifo (
  // write side
  input  wire                        wr_clk,
  input  wire                        wr_rst_n,
  input  wire afifo_pkg::wr_req_t    wr_req,
  output afifo_pkg::wr_status_t      wr_status,
  // read side
  input  wire                        rd_clk,
  input  wire                        rd_rst_n,
  input  wire                        rd_en,
  output afifo_pkg::rd_resp_t        rd_resp,
  output afifo_pkg::rd_status_t      rd_status
);

  import afifo_pkg::*;

  logic                         ram_we;
  logic [`AFIFO_ADDR_WIDTH-1:0] ram_waddr;
  logic                         ram_re;
  logic [`AFIFO_ADDR_WIDTH-1:0] ram_raddr;
  data_t                        rdata;
  logic                         rd_valid;

  ptr_t wr_ptr_gray;  // wr_clk domain
  ptr_t rd_ptr_gray;  // rd_clk domain
  ptr_t wr_ptr_sync;  // write pointer as seen in rd_clk
  ptr_t rd_ptr_sync;  // read pointer as seen in wr_clk

  // ####################################################################
  // write domain
  // ####################################################################

  afifo_wr_ctrl u_wr_ctrl (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_req      (wr_req),
    .rd_ptr_sync (rd_ptr_sync),
    .wr_status   (wr_status),
    .ram_we      (ram_we),
    .ram_waddr   (ram_waddr),
    .wr_ptr_gray (wr_ptr_gray)
  );

  afifo_ptr_sync u_rd_ptr_sync (
    .clk      (wr_clk),
    .rst_n    (wr_rst_n),
    .ptr_gray (rd_ptr_gray),
    .ptr_bin  (rd_ptr_sync)
  );

  // ####################################################################
  // read domain
  // ####################################################################

  afifo_rd_ctrl u_rd_ctrl (
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .rd_en       (rd_en),
    .wr_ptr_sync (wr_ptr_sync),
    .rd_status   (rd_status),
    .ram_re      (ram_re),
    .ram_raddr   (ram_raddr),
    .rd_ptr_gray (rd_ptr_gray),
    .rd_valid    (rd_valid)
  );

  afifo_ptr_sync u_wr_ptr_sync (
    .clk      (rd_clk),
    .rst_n    (rd_rst_n),
    .ptr_gray (wr_ptr_gray),
    .ptr_bin  (wr_ptr_sync)
  );

  afifo_ram u_ram (
    .wr_clk (wr_clk),
    .we     (ram_we),
    .waddr  (ram_waddr),
    .wdata  (wr_req.data),
    .rd_clk (rd_clk),
    .re     (ram_re),
    .raddr  (ram_raddr),
    .rdata  (rdata)
  );

  assign rd_resp = '{valid: rd_valid, data: rdata};

endmodule

`default_nettype wire

//--- afifo_checker.sv
`timescale 1ns/10ps

`include "afifo_cfg.svh"

`default_nettype none

module afifo_checker (
  input wire                        wr_clk,
  input wire                        wr_rst_n,
  input wire                        rd_clk,
  input wire                        rd_rst_n,
  input wire afifo_pkg::wr_req_t    wr_req,
  input wire afifo_pkg::wr_status_t wr_status,
  input wire                        rd_en,
  input wire afifo_pkg::rd_resp_t   rd_resp,
  input wire afifo_pkg::rd_status_t rd_status
);

  import afifo_pkg::*;

  data_t ref_q [$];  // accepted writes, oldest first
  int    wr_acc_cnt = 0;
  int    rd_acc_cnt = 0;
  int    errors     = 0;

  // ####################################################################
  // reference queue
  // ####################################################################

  always @(posedge wr_clk) begin
    if (wr_rst_n && wr_req.en && !wr_status.full) begin
      ref_q.push_back(wr_req.data);
      wr_acc_cnt++;
    end
  end

  always @(posedge rd_clk) begin
    data_t exp_data;
    if (rd_rst_n) begin
      if (rd_en && !rd_status.empty) begin
        rd_acc_cnt++;
      end
      if (rd_resp.valid) begin
        if (ref_q.size() == 0) begin
          $display("%0t: a read word came out but no accepted write is left", $time);
          errors++;
        end else begin
          exp_data = ref_q.pop_front();
          if (rd_resp.data !== exp_data) begin
            $display("[FAIL] %0t rd_resp.data expected %02h got %02h",
                     $time, exp_data, rd_resp.data);
            errors++;
          end
        end
      end
    end
  end

  function automatic int held_words();
    return wr_acc_cnt - rd_acc_cnt;
  endfunction

  function automatic int ref_words();
    return ref_q.size();
  endfunction

  task automatic compare_value(input string name, input int exp_val, input int act_val);
    if (act_val != exp_val) begin
      $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp_val, act_val);
      errors++;
    end
  endtask

  // exact only while the read side is idle and its pointer has crossed
  task automatic wr_flag_rules();
    compare_value("wr_status.full", int'(held_words() == `AFIFO_DEPTH), int'(wr_status.full));
    compare_value("wr_status.afull", int'(held_words() >= `AFIFO_AFULL), int'(wr_status.afull));
  endtask

  task automatic rd_flag_rules();
    compare_value("rd_status.empty", int'(held_words() == 0), int'(rd_status.empty));
    compare_value("rd_status.aempty", int'(held_words() <= `AFIFO_AEMPTY),
                  int'(rd_status.aempty));
  endtask

endmodule

`default_nettype wire

//--- afifo_assertions.sv
`timescale 1ns/10ps

`default_nettype none

module afifo_assertions (
  input wire                        wr_clk,
  input wire                        wr_rst_n,
  input wire                        rd_clk,
  input wire                        rd_rst_n,
  input wire                        rd_en,
  input wire afifo_pkg::wr_status_t wr_status,
  input wire afifo_pkg::rd_status_t rd_status,
  input wire afifo_pkg::rd_resp_t   rd_resp,
  input wire afifo_pkg::ptr_t       wr_ptr_gray,
  input wire afifo_pkg::ptr_t       wr_ptr_sync,
  input wire afifo_pkg::ptr_t       rd_ptr_sync
);

  int fail_cnt = 0;

  // a flag only clears after the other side's pointer has moved
  full_clear: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    $fell(wr_status.full) && $past(wr_rst_n) |-> $past(rd_ptr_sync) != $past(rd_ptr_sync, 2))
    else begin
      fail_cnt++;
      $error("full cleared with no read pointer change");
    end

  empty_clear: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    $fell(rd_status.empty) && $past(rd_rst_n) |-> $past(wr_ptr_sync) != $past(wr_ptr_sync, 2))
    else begin
      fail_cnt++;
      $error("empty cleared with no write pointer change");
    end

  no_valid_on_empty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    rd_en && rd_status.empty |=> !rd_resp.valid)
    else begin
      fail_cnt++;
      $error("read data valid after a read on empty");
    end

  hold_ptr_on_full: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    wr_status.full |=> $stable(wr_ptr_gray))
    else begin
      fail_cnt++;
      $error("write pointer moved while full");
    end

endmodule

bind async_fifo afifo_assertions asrt0 (.*);

`default_nettype wire

//--- tb_async_fifo.sv
`timescale 1ns/10ps

`include "afifo_cfg.svh"

`default_nettype none

module tb_async_fifo;

  import afifo_pkg::*;

  localparam int MAX_LINES = 32;
  localparam int LIMIT     = 40;  // cycles per wait and per random word

  logic        wr_clk = 1'b0;
  logic        rd_clk = 1'b0;
  logic        wr_rst_n;
  logic        rd_rst_n;
  logic        rd_en;
  wr_req_t     wr_req;
  wr_status_t  wr_status;
  rd_resp_t    rd_resp;
  rd_status_t  rd_status;
  logic [15:0] pat [3*MAX_LINES];  // phase, count, start word per line
  bit          aborted = 1'b0;
  int          passed  = 0;
  int          failed  = 0;

  always #2 wr_clk = ~wr_clk;
  always #3.5 rd_clk = ~rd_clk;

  async_fifo dut0 (.*);

  afifo_checker chk0 (.*);

  function automatic int total_errors();
    return chk0.errors + dut0.asrt0.fail_cnt;
  endfunction

  // ####################################################################
  // waits and phases
  // ####################################################################

  task automatic wait_settled();
    int n;
    n = 0;
    while ((dut0.u_rd_ptr_sync.sync_q2 != dut0.rd_ptr_gray ||
            dut0.u_wr_ptr_sync.sync_q2 != dut0.wr_ptr_gray) && n < LIMIT) begin
      @(posedge rd_clk);
      #1;
      n++;
    end
    if (n >= LIMIT) begin
      $display("timeout: the pointers never settled across the clock domains");
      aborted = 1'b1;
    end
    @(posedge wr_clk);  // flags register from the settled copies
    @(posedge rd_clk);
    #1;
  endtask

  task automatic fill_words(input int count, input int start);
    int base;
    int room;
    base = chk0.wr_acc_cnt;
    room = `AFIFO_DEPTH - chk0.held_words();
    for (int i = 0; i <= count; i++) begin
      @(posedge wr_clk);
      #1;
      chk0.wr_flag_rules();
      wr_req.en   = (i < count);
      wr_req.data = data_t'(start + i);
    end
    chk0.compare_value("accepted writes", (count < room) ? count : room,
                       chk0.wr_acc_cnt - base);
  endtask

  task automatic drain_words(input int count);
    int base;
    int held;
    base = chk0.rd_acc_cnt;
    held = chk0.held_words();
    for (int i = 0; i <= count + 1; i++) begin  // one extra edge for the last word
      @(posedge rd_clk);
      #1;
      chk0.rd_flag_rules();
      rd_en = (i < count);
    end
    chk0.compare_value("accepted reads", (count < held) ? count : held,
                       chk0.rd_acc_cnt - base);
    // every accepted read has delivered its word by now
    chk0.compare_value("reference queue size", chk0.held_words(), chk0.ref_words());
  endtask

  task automatic random_traffic(input int count, input int start);
    int base;
    bit wr_done;
    base    = chk0.wr_acc_cnt;
    wr_done = 1'b0;
    fork
      begin : writer
        int n;
        n = 0;
        while (chk0.wr_acc_cnt - base < count && n < count * LIMIT) begin
          @(posedge wr_clk);
          #1;
          wr_req.en   = ($urandom % 4) != 0;
          wr_req.data = data_t'(start + chk0.wr_acc_cnt - base);  // held until taken
          n++;
        end
        wr_req.en = 1'b0;
        if (chk0.wr_acc_cnt - base < count) begin
          $display("timeout: random writes were not all accepted");
          aborted = 1'b1;
        end
        wr_done = 1'b1;
      end
      begin : reader
        int n;
        n = 0;
        while (!(wr_done && chk0.held_words() == 0) && n < (count + 1) * LIMIT) begin
          @(posedge rd_clk);
          #1;
          rd_en = wr_done || (($urandom % 3) != 0);  // drain once the writer stops
          n++;
        end
        rd_en = 1'b0;
        if (!(wr_done && chk0.held_words() == 0)) begin
          $display("timeout: the final drain never emptied the FIFO");
          aborted = 1'b1;
        end
      end
    join
    @(posedge rd_clk);
    #1;
    chk0.compare_value("accepted writes", count, chk0.wr_acc_cnt - base);
    chk0.compare_value("reference queue size", 0, chk0.ref_words());
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (total_errors() == errs_before && !aborted) begin
      passed++;
      $display("%s: ok", name);
    end else begin
      failed++;
      $display("%s: %0d errors", name, total_errors() - errs_before);
    end
  endtask

  // ####################################################################
  // main sequence
  // ####################################################################

  initial begin
    int line;
    int phase;
    int count;
    int errs;
    void'($urandom(32'h5e4ebe5a));
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    wr_req   = '0;
    rd_en    = 1'b0;
    $readmemh("afifo_patterns.txt", pat);
    fork
      begin
        repeat (8) @(posedge wr_clk);
        #1 wr_rst_n = 1'b1;
      end
      begin
        repeat (8) @(posedge rd_clk);
        #1 rd_rst_n = 1'b1;
      end
    join

    errs = total_errors();
    wait_settled();
    chk0.wr_flag_rules();
    chk0.rd_flag_rules();
    report_test("reset flags", errs);

    for (line = 0; line < MAX_LINES && !aborted; line++) begin
      phase = int'(pat[3*line]);
      if (phase == 0) break;
      count = int'(pat[3*line+1]);
      errs  = total_errors();
      wait_settled();
      case (phase)
        1: fill_words(count, int'(pat[3*line+2]));
        2: drain_words(count);
        3: random_traffic(count, int'(pat[3*line+2]));
        default: begin
          $display("pattern line %0d has an unknown phase code %0d", line, phase);
          aborted = 1'b1;
        end
      endcase
      wait_settled();
      chk0.wr_flag_rules();
      chk0.rd_flag_rules();
      report_test($sformatf("line %0d phase %0d, %0d words", line, phase, count), errs);
    end

    $display("tests passed %0d, failed %0d, errors %0d", passed, failed, total_errors());
    if (failed == 0 && total_errors() == 0 && !aborted) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- afifo_patterns.txt
// columns: phase code, word count, start data word, all hex
// phase 1 fills with reads stopped, 2 drains with writes stopped, 3 is random, 0 ends
1 14 00
2 18 00
1 0b 40
1 03 60
2 06 00
2 08 00
1 0c 80
2 10 00
3 c8 10
3 64 a0
1 10 c0
2 14 00
3 40 33
0 00 00

//--- verilog.f
+incdir+.
afifo_pkg.sv
afifo_ram.sv
afifo_ptr_sync.sv
afifo_wr_ctrl.sv
afifo_rd_ctrl.sv
async_fifo.sv
afifo_checker.sv
afifo_assertions.sv
tb_async_fifo.sv

//--- run_sim.sh
#!/bin/sh
# build and run the async FIFO testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_async_fifo -f verilog.f
./obj_dir/Vtb_async_fifo > sim.log 2>&1 || true
cat sim.log
if grep -qx "Test passed" sim.log; then
  echo "simulation PASS"
else
  echo "simulation FAIL"
  exit 1
fi
